// File: vlog.f
logic/bp_pkg.sv
logic/bp_update_if.sv
logic/direction_predictor.sv
logic/target_predictor.sv
logic/prediction_merge.sv
logic/branch_predictor.sv
verif/branch_predictor_properties.sv
verif/branch_predictor_tb.sv

// File: Bender.yml
package:
  name: branch_predictor

sources:
  - logic/bp_pkg.sv
  - logic/bp_update_if.sv
  - logic/direction_predictor.sv
  - logic/target_predictor.sv
  - logic/prediction_merge.sv
  - logic/branch_predictor.sv
  - target: simulation
    files:
      - verif/branch_predictor_properties.sv
      - verif/branch_predictor_tb.sv

// File: verif/branch_predictor_tb.sv
`timescale 1ns/10ps
`default_nettype none

module branch_predictor_tb import bp_pkg::*; ();

    typedef struct {
        logic                  valid;
        logic [addr_width-1:0] pc;
        logic [addr_width-1:0] npc;
        branch_kind_t          kind;
        logic                  taken;
        logic [2:0]            mis;
        logic [addr_width-1:0] look;
    } step_t;

    logic                  clk;
    logic                  rstn;
    logic [addr_width-1:0] pc;
    logic                  upd_valid;
    logic [addr_width-1:0] upd_pc;
    logic [addr_width-1:0] upd_npc;
    branch_kind_t          upd_kind;
    logic                  upd_taken;
    logic                  upd_mis_taken;
    logic                  upd_mis_kind;
    logic                  upd_mis_npc;
    logic [1:0]            upd_choice;
    branch_kind_t          pred_kind;
    logic                  pred_taken;
    logic [addr_width-1:0] pred_npc;
    logic [1:0]            pred_choice;
    logic [cnt_width-1:0]  mis_npc_count;
    logic [cnt_width-1:0]  mis_kind_count;
    logic [cnt_width-1:0]  mis_taken_count;
    logic [cnt_width-1:0]  update_count;

    step_t       steps[$];
    logic [31:0] seed = 32'haa7e_f715;
    int          cycle_count = 0;
    int          max_cycles = 50;

    // reference model state
    branch_kind_t          m_kind  [2**idx_width];
    logic [1:0]            m_cnt   [2**idx_width];
    logic                  m_valid [2**idx_width];
    logic [tag_width-1:0]  m_tag   [2**idx_width];
    logic [addr_width-1:0] m_tgt   [2**idx_width];
    logic [addr_width-1:0] m_stack [ras_depth];
    int                    m_sp;
    logic [idx_width-1:0]  m_ghr;
    logic [cnt_width-1:0]  m_npc_count;
    logic [cnt_width-1:0]  m_kind_count;
    logic [cnt_width-1:0]  m_taken_count;
    logic [cnt_width-1:0]  m_update_count;

    branch_predictor u_branch_predictor (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [addr_width-1:0] rand_pc();
        logic [31:0] r;
        r = next_rand();
        return r[31:2];
    endfunction

    // low slice xor the slice above it
    function automatic logic [idx_width-1:0] table_index(input logic [addr_width-1:0] p);
        return p[idx_width-1:0] ^ p[2*idx_width-1:idx_width];
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_kind(input string name, input branch_kind_t got, input branch_kind_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAIL %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAIL %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input logic [addr_width-1:0] got,
                              input logic [addr_width-1:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAIL %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input logic [cnt_width-1:0] got,
                               input logic [cnt_width-1:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAIL %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic add_step(input logic v, input logic [addr_width-1:0] p,
                            input logic [addr_width-1:0] np, input branch_kind_t k,
                            input logic t, input logic [2:0] m, input logic [addr_width-1:0] l);
        step_t s;
        s.valid = v;
        s.pc    = p;
        s.npc   = np;
        s.kind  = k;
        s.taken = t;
        s.mis   = m;
        s.look  = l;
        steps.push_back(s);
    endtask

    task automatic model_reset();
        for (int i = 0; i < 2**idx_width; i++) begin
            m_kind[i]  = kind_none;
            m_cnt[i]   = 2'b01;
            m_valid[i] = 1'b0;
        end
        m_sp = 0;
        m_ghr = '0;
        m_npc_count = '0;
        m_kind_count = '0;
        m_taken_count = '0;
        m_update_count = '0;
    endtask

    task automatic model_update(input step_t s);
        logic [idx_width-1:0] i;
        logic [idx_width-1:0] g;
        i = table_index(s.pc);
        if (s.kind == kind_cond) begin
            g = i ^ m_ghr;
            if (s.taken && m_cnt[g] != 2'b11) begin
                m_cnt[g] = m_cnt[g] + 2'b01;
            end else if (!s.taken && m_cnt[g] != 2'b00) begin
                m_cnt[g] = m_cnt[g] - 2'b01;
            end
            m_ghr = {m_ghr[idx_width-2:0], s.taken};
        end
        m_kind[i] = s.kind;
        if (s.taken && s.kind != kind_ret) begin
            m_valid[i] = 1'b1;
            m_tag[i]   = s.pc[idx_width +: tag_width];
            m_tgt[i]   = s.npc;
        end
        // full stack keeps its depth, top slot replaced
        if (s.kind == kind_call) begin
            if (m_sp < ras_depth) begin
                m_stack[m_sp] = s.pc + 30'd1;
                m_sp++;
            end else begin
                m_stack[ras_depth-1] = s.pc + 30'd1;
            end
        end else if (s.kind == kind_ret && m_sp > 0) begin
            m_sp--;
        end
        m_npc_count    = m_npc_count + s.mis[0];
        m_kind_count   = m_kind_count + s.mis[1];
        m_taken_count  = m_taken_count + s.mis[2];
        m_update_count = m_update_count + 1;
    endtask

    task automatic check_prediction(input logic [addr_width-1:0] look);
        logic [idx_width-1:0]  i;
        branch_kind_t          k;
        logic                  taken;
        logic                  hit;
        logic                  use_ras;
        logic [addr_width-1:0] npc;
        i = table_index(look);
        k = m_kind[i];
        taken = (k == kind_none) ? 1'b0 : (k == kind_cond) ? m_cnt[i ^ m_ghr][1] : 1'b1;
        hit = m_valid[i] && (m_tag[i] == look[idx_width +: tag_width]);
        use_ras = taken && (k == kind_ret) && (m_sp > 0);
        npc = use_ras ? m_stack[m_sp-1] : (taken && hit) ? m_tgt[i] : look + 30'd1;
        check_kind("pred_kind", pred_kind, k);
        check_bit("pred_taken", pred_taken, taken);
        check_addr("pred_npc", pred_npc, npc);
        check_bit("pred_choice[1]", pred_choice[1], use_ras);
        check_bit("pred_choice[0]", pred_choice[0], k == kind_cond);
        check_count("mis_npc_count", mis_npc_count, m_npc_count);
        check_count("mis_kind_count", mis_kind_count, m_kind_count);
        check_count("mis_taken_count", mis_taken_count, m_taken_count);
        check_count("update_count", update_count, m_update_count);
    endtask

    task automatic build_table();
        logic [addr_width-1:0] a;
        logic [addr_width-1:0] r;
        logic [31:0]           x;
        // lookups straight after reset
        repeat (4) add_step(1'b0, '0, '0, kind_none, 1'b0, 3'b000, rand_pc());
        // taken ten times, then not taken ten times
        // history saturates, so one counter sees repeated training
        a = rand_pc();
        for (int n = 0; n < 20; n++) begin
            add_step(1'b1, a, a + 30'd5, kind_cond, n < 10, 3'b000, a);
        end
        // bit 12 sits in the tag and outside the index fold
        a = rand_pc();
        add_step(1'b1, a, rand_pc(), kind_jump, 1'b1, 3'b000, a);
        add_step(1'b0, '0, '0, kind_none, 1'b0, 3'b000, a ^ (30'd1 << (2 * idx_width)));
        a = rand_pc();
        add_step(1'b1, a, rand_pc(), kind_indirect, 1'b1, 3'b000, a);
        // jump at r leaves a target for when the stack runs dry
        r = rand_pc();
        add_step(1'b1, r, rand_pc(), kind_jump, 1'b1, 3'b000, r);
        repeat (3) begin
            a = rand_pc();
            add_step(1'b1, a, rand_pc(), kind_call, 1'b1, 3'b000, a);
        end
        repeat (3) add_step(1'b1, r, rand_pc(), kind_ret, 1'b1, 3'b000, r);
        repeat (20) begin
            x = next_rand();
            add_step(x[0] | x[5], rand_pc(), rand_pc(), branch_kind_t'(x[31:29] % 3'd6),
                     x[1], x[4:2], rand_pc());
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            stop_with_failure("run did not finish before the cycle limit");
        end
    end

    initial begin
        rstn = 1'b0;
        pc = '0;
        upd_valid = 1'b0;
        upd_pc = '0;
        upd_npc = '0;
        upd_kind = kind_none;
        upd_taken = 1'b0;
        upd_mis_taken = 1'b0;
        upd_mis_kind = 1'b0;
        upd_mis_npc = 1'b0;
        upd_choice = 2'b00;
        model_reset();
        build_table();
        max_cycles = steps.size() * 4 + 50;
        repeat (4) @(posedge clk);
        #1;
        rstn = 1'b1;
        foreach (steps[n]) begin
            @(posedge clk);
            #1;
            pc = steps[n].look;
            upd_valid = steps[n].valid;
            upd_pc = steps[n].pc;
            upd_npc = steps[n].npc;
            upd_kind = steps[n].kind;
            upd_taken = steps[n].taken;
            upd_mis_taken = steps[n].mis[2];
            upd_mis_kind = steps[n].mis[1];
            upd_mis_npc = steps[n].mis[0];
            upd_choice = steps[n].mis[1:0];
            @(posedge clk);
            #1;
            upd_valid = 1'b0;
            if (steps[n].valid) begin
                model_update(steps[n]);
            end
            // lookup sees the state written at the edge
            #1;
            check_prediction(steps[n].look);
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/branch_predictor_properties.sv
`timescale 1ns/10ps
`default_nettype none

module branch_predictor_properties import bp_pkg::*; (
    input logic                 clk,
    input logic                 rstn,
    input branch_kind_t         pred_kind,
    input logic                 pred_taken,
    input logic [1:0]           pred_choice,
    input logic [cnt_width-1:0] mis_npc_count,
    input logic [cnt_width-1:0] mis_kind_count,
    input logic [cnt_width-1:0] mis_taken_count,
    input logic [cnt_width-1:0] update_count
);

    a_none_not_taken: assert property (@(posedge clk) disable iff (!rstn)
        (pred_kind == kind_none) |-> !pred_taken)
        else $error("taken predicted for a non-branch");

    a_stack_only_for_ret: assert property (@(posedge clk) disable iff (!rstn)
        pred_choice[1] |-> (pred_kind == kind_ret))
        else $error("stack chosen for a kind other than return");

    // statistics only move up between resets
    a_counts_monotonic: assert property (@(posedge clk) disable iff (!rstn)
        $past(rstn) |-> (mis_npc_count >= $past(mis_npc_count))
                     && (mis_kind_count >= $past(mis_kind_count))
                     && (mis_taken_count >= $past(mis_taken_count))
                     && (update_count >= $past(update_count)))
        else $error("statistics counter went down");

endmodule

bind branch_predictor branch_predictor_properties u_branch_predictor_properties (.*);

`default_nettype wire

// File: logic/branch_predictor.sv
`timescale 1ns/10ps
`default_nettype none

module branch_predictor import bp_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic [addr_width-1:0] pc,
    // resolved branch from execute
    input  logic                  upd_valid,
    input  logic [addr_width-1:0] upd_pc,
    input  logic [addr_width-1:0] upd_npc,
    input  branch_kind_t          upd_kind,
    input  logic                  upd_taken,
    input  logic                  upd_mis_taken,
    input  logic                  upd_mis_kind,
    input  logic                  upd_mis_npc,
    input  logic [1:0]            upd_choice,
    // prediction for pc, same cycle
    output branch_kind_t          pred_kind,
    output logic                  pred_taken,
    output logic [addr_width-1:0] pred_npc,
    output logic [1:0]            pred_choice,
    output logic [cnt_width-1:0]  mis_npc_count,
    output logic [cnt_width-1:0]  mis_kind_count,
    output logic [cnt_width-1:0]  mis_taken_count,
    output logic [cnt_width-1:0]  update_count
);

    logic                  pred_counter_taken;
    logic                  btb_hit;
    logic [addr_width-1:0] btb_target;
    logic [addr_width-1:0] ras_top;
    logic                  ras_empty;

    bp_update_if upd ();

    assign upd.valid     = upd_valid;
    assign upd.pc        = upd_pc;
    assign upd.npc       = upd_npc;
    assign upd.kind      = upd_kind;
    assign upd.taken     = upd_taken;
    assign upd.mis_taken = upd_mis_taken;
    assign upd.mis_kind  = upd_mis_kind;
    assign upd.mis_npc   = upd_mis_npc;
    assign upd.choice    = upd_choice;

    direction_predictor u_direction_predictor (
        .clk                (clk),
        .rstn               (rstn),
        .pc                 (pc),
        .upd                (upd.sink),
        .pred_kind          (pred_kind),
        .pred_counter_taken (pred_counter_taken)
    );

    target_predictor u_target_predictor (
        .clk        (clk),
        .rstn       (rstn),
        .pc         (pc),
        .upd        (upd.sink),
        .btb_hit    (btb_hit),
        .btb_target (btb_target),
        .ras_top    (ras_top),
        .ras_empty  (ras_empty)
    );

    prediction_merge u_prediction_merge (
        .clk                (clk),
        .rstn               (rstn),
        .pc                 (pc),
        .pred_kind          (pred_kind),
        .pred_counter_taken (pred_counter_taken),
        .btb_hit            (btb_hit),
        .btb_target         (btb_target),
        .ras_top            (ras_top),
        .ras_empty          (ras_empty),
        .upd                (upd.sink),
        .pred_taken         (pred_taken),
        .pred_npc           (pred_npc),
        .pred_choice        (pred_choice),
        .mis_npc_count      (mis_npc_count),
        .mis_kind_count     (mis_kind_count),
        .mis_taken_count    (mis_taken_count),
        .update_count       (update_count)
    );

endmodule

`default_nettype wire

// File: logic/prediction_merge.sv
`timescale 1ns/10ps
`default_nettype none

module prediction_merge import bp_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic [addr_width-1:0] pc,
    input  branch_kind_t          pred_kind,
    input  logic                  pred_counter_taken,
    input  logic                  btb_hit,
    input  logic [addr_width-1:0] btb_target,
    input  logic [addr_width-1:0] ras_top,
    input  logic                  ras_empty,
    bp_update_if.sink             upd,
    output logic                  pred_taken,
    output logic [addr_width-1:0] pred_npc,
    output logic [1:0]            pred_choice,
    output logic [cnt_width-1:0]  mis_npc_count,
    output logic [cnt_width-1:0]  mis_kind_count,
    output logic [cnt_width-1:0]  mis_taken_count,
    output logic [cnt_width-1:0]  update_count
);

    logic use_ras;
    logic use_counter;

    // direction from kind, counter only for conditionals
    always_comb begin
        case (pred_kind)
            kind_none: pred_taken = 1'b0;
            kind_cond: pred_taken = pred_counter_taken;
            default:   pred_taken = 1'b1;
        endcase
    end

    assign use_counter = (pred_kind == kind_cond);
    assign use_ras     = pred_taken && (pred_kind == kind_ret) && !ras_empty;

    // stack first, then target buffer, else fall through
    assign pred_npc = use_ras                ? ras_top    :
                      (pred_taken && btb_hit) ? btb_target :
                      pc + 1'b1;

    assign pred_choice = {use_ras, use_counter};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mis_npc_count   <= '0;
            mis_kind_count  <= '0;
            mis_taken_count <= '0;
            update_count    <= '0;
        end else if (upd.valid) begin
            if (upd.mis_npc) mis_npc_count <= mis_npc_count + 1'b1;
            if (upd.mis_kind) mis_kind_count <= mis_kind_count + 1'b1;
            if (upd.mis_taken) mis_taken_count <= mis_taken_count + 1'b1;
            update_count <= update_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: logic/target_predictor.sv
`timescale 1ns/10ps
`default_nettype none

module target_predictor import bp_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic [addr_width-1:0] pc,
    bp_update_if.sink             upd,
    output logic                  btb_hit,
    output logic [addr_width-1:0] btb_target,
    output logic [addr_width-1:0] ras_top,
    output logic                  ras_empty
);

    localparam int n_entries = 1 << idx_width;
    localparam int ptr_width = $clog2(ras_depth);

    // direct-mapped target buffer
    logic                  btb_valid   [n_entries];
    logic [tag_width-1:0]  btb_tag_mem [n_entries];
    logic [addr_width-1:0] btb_tgt_mem [n_entries];

    // return stack, ras_ptr counts live entries
    logic [addr_width-1:0] ras_mem [ras_depth];
    logic [ptr_width:0]    ras_ptr;
    logic [ptr_width-1:0]  ras_top_idx;
    logic                  ras_full;

    logic [idx_width-1:0]  lookup_idx;
    logic [idx_width-1:0]  upd_idx;
    logic                  btb_write;
    logic                  ras_push;
    logic                  ras_pop;

    assign lookup_idx = pc_index(pc);
    assign upd_idx    = pc_index(upd.pc);

    assign btb_hit    = btb_valid[lookup_idx] && (btb_tag_mem[lookup_idx] == pc_tag(pc));
    assign btb_target = btb_tgt_mem[lookup_idx];

    // returns are left to the stack
    assign btb_write = upd.valid && upd.taken && (upd.kind != kind_ret);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < n_entries; i++) begin
                btb_valid[i] <= 1'b0;
            end
        end else if (btb_write) begin
            btb_valid[upd_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (btb_write) begin
            btb_tag_mem[upd_idx] <= pc_tag(upd.pc);
            btb_tgt_mem[upd_idx] <= upd.npc;
        end
    end

    assign ras_push = upd.valid && (upd.kind == kind_call);
    assign ras_pop  = upd.valid && (upd.kind == kind_ret);

    assign ras_empty   = (ras_ptr == '0);
    assign ras_full    = (ras_ptr == ras_depth[ptr_width:0]);
    assign ras_top_idx = ras_ptr[ptr_width-1:0] - 1'b1;
    assign ras_top     = ras_mem[ras_top_idx];

    // saturating pointer
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ras_ptr <= '0;
        end else if (ras_push && !ras_full) begin
            ras_ptr <= ras_ptr + 1'b1;
        end else if (ras_pop && !ras_empty) begin
            ras_ptr <= ras_ptr - 1'b1;
        end
    end

    // when full the top entry gets overwritten
    always_ff @(posedge clk) begin
        if (ras_push) begin
            if (ras_full) begin
                ras_mem[ras_top_idx] <= upd.pc + 1'b1;
            end else begin
                ras_mem[ras_ptr[ptr_width-1:0]] <= upd.pc + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/direction_predictor.sv
`timescale 1ns/10ps
`default_nettype none

module direction_predictor import bp_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic [addr_width-1:0] pc,
    bp_update_if.sink             upd,
    output branch_kind_t          pred_kind,
    output logic                  pred_counter_taken
);

    localparam int n_entries = 1 << idx_width;

    branch_kind_t         kind_tbl [n_entries];
    logic [1:0]           cnt_tbl  [n_entries];
    logic [idx_width-1:0] ghr;

    logic [idx_width-1:0] lookup_idx;
    logic [idx_width-1:0] lookup_gidx;
    logic [idx_width-1:0] upd_idx;
    logic [idx_width-1:0] upd_gidx;
    logic [1:0]           upd_cnt;
    logic [1:0]           upd_cnt_next;

    // lookup side, read asynchronously
    assign lookup_idx  = pc_index(pc);
    assign lookup_gidx = lookup_idx ^ ghr;

    assign pred_kind          = kind_tbl[lookup_idx];
    assign pred_counter_taken = cnt_tbl[lookup_gidx][1];

    // training side
    assign upd_idx  = pc_index(upd.pc);
    assign upd_gidx = upd_idx ^ ghr;
    assign upd_cnt  = cnt_tbl[upd_gidx];

    // two-bit saturating step toward the outcome
    always_comb begin
        upd_cnt_next = upd_cnt;
        if (upd.taken) begin
            if (upd_cnt != 2'b11) begin
                upd_cnt_next = upd_cnt + 2'b01;
            end
        end else begin
            if (upd_cnt != 2'b00) begin
                upd_cnt_next = upd_cnt - 2'b01;
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < n_entries; i++) begin
                kind_tbl[i] <= kind_none;
            end
        end else if (upd.valid) begin
            kind_tbl[upd_idx] <= upd.kind;
        end
    end

    // counters start weakly not taken
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < n_entries; i++) begin
                cnt_tbl[i] <= 2'b01;
            end
        end else if (upd.valid && upd.kind == kind_cond) begin
            cnt_tbl[upd_gidx] <= upd_cnt_next;
        end
    end

    // global history, only conditional outcomes shift in
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ghr <= '0;
        end else if (upd.valid && upd.kind == kind_cond) begin
            ghr <= {ghr[idx_width-2:0], upd.taken};
        end
    end

endmodule

`default_nettype wire

// File: logic/bp_update_if.sv
`timescale 1ns/10ps
`default_nettype none

interface bp_update_if import bp_pkg::*; ();

    logic                  valid;
    logic [addr_width-1:0] pc;
    logic [addr_width-1:0] npc;
    branch_kind_t          kind;
    logic                  taken;
    // earlier guess was wrong in these parts
    logic                  mis_taken;
    logic                  mis_kind;
    logic                  mis_npc;
    // 1: stack, 0: counter
    logic [1:0]            choice;

    modport source (
        output valid, pc, npc, kind, taken, mis_taken, mis_kind, mis_npc, choice
    );

    modport sink (
        input valid, pc, npc, kind, taken, mis_taken, mis_kind, mis_npc, choice
    );

endinterface

`default_nettype wire

// File: logic/bp_pkg.sv
`default_nettype none

package bp_pkg;

    // word-address pc
    localparam int addr_width = 30;

    // 64 entries per table
    localparam int idx_width = 6;
    localparam int tag_width = 8;

    localparam int ras_depth = 8;

    // statistics counters
    localparam int cnt_width = 32;

    typedef enum logic [2:0] {
        kind_none     = 3'd0,
        kind_jump     = 3'd1,
        kind_call     = 3'd2,
        kind_ret      = 3'd3,
        kind_indirect = 3'd4,
        kind_cond     = 3'd5
    } branch_kind_t;

    // fold low two slices of the pc into one table index
    function automatic logic [idx_width-1:0] pc_index(
        input logic [addr_width-1:0] pc
    );
        return pc[idx_width-1:0] ^ pc[2*idx_width-1:idx_width];
    endfunction

    // bits right above the index slice
    function automatic logic [tag_width-1:0] pc_tag(
        input logic [addr_width-1:0] pc
    );
        return pc[idx_width +: tag_width];
    endfunction

endpackage

`default_nettype wire
